// ==== cacheFlush_settings.svh ====
/*
 * Cache flush subsystem sizes
 * Geometry of both caches, line data width and writeback buffer depth
 */
`ifndef CACHE_FLUSH_SETTINGS_SVH
`define CACHE_FLUSH_SETTINGS_SVH

// Line index width, one index per line
`define CF_INDEX_BITS 4

// Must equal 2 ** CF_INDEX_BITS
`define CF_LINES 16

`define CF_TAG_BITS 8
`define CF_DATA_BITS 32

// Default number of writeback entries buffered before memory
`define CF_FIFO_DEPTH 4

`endif

// ==== cacheFlushPkg.sv ====
/*
 * Cache flush package
 * Width typedefs and state machine encodings shared by the flush blocks
 */
`include "cacheFlush_settings.svh"

package cacheFlushPkg;

    typedef logic [`CF_INDEX_BITS-1:0] lineIndexT;
    typedef logic [`CF_TAG_BITS-1:0] tagT;
    typedef logic [`CF_DATA_BITS-1:0] lineDataT;

    // Line address toward memory: tag in the upper bits, index below
    typedef logic [`CF_TAG_BITS+`CF_INDEX_BITS-1:0] memAddrT;

    typedef enum logic [1:0] {
        phaseFree        = 2'd0,
        phaseSendRequest = 2'd1,
        phaseProcessing  = 2'd2,
        phaseWaiting     = 2'd3
    } flushPhaseT;

    typedef enum logic [1:0] {walkIdle, walkScan, walkDone} walkStateT;

endpackage

// ==== cacheFlushManager.sv ====
/*
 * Cache flush manager
 * Waits for both caches to go idle, pulses a flush into each, collects
 * their completions in any order and holds flushComplete until released
 */
`timescale 1ns/10ps

module cacheFlushManager (
    input  logic clk,
    input  logic rstN,
    input  logic flushReq,
    output logic flushComplete,
    input  logic icFlushReqAck,
    input  logic dcFlushReqAck,
    output logic icFlushReq,
    output logic dcFlushReq,
    input  logic icFlushComplete,
    input  logic dcFlushComplete
);

    cacheFlushPkg::flushPhaseT phaseReg, phaseNext;

    // Completion seen so far from each cache
    logic icDoneReg, icDoneNext;
    logic dcDoneReg, dcDoneNext;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phaseReg  <= cacheFlushPkg::phaseFree;
            icDoneReg <= 1'b0;
            dcDoneReg <= 1'b0;
        end else begin
            phaseReg  <= phaseNext;
            icDoneReg <= icDoneNext;
            dcDoneReg <= dcDoneNext;
        end
    end

    always_comb begin
        phaseNext     = phaseReg;
        icDoneNext    = icDoneReg;
        dcDoneNext    = dcDoneReg;
        icFlushReq    = 1'b0;
        dcFlushReq    = 1'b0;
        flushComplete = 1'b0;

        case (phaseReg)
            cacheFlushPkg::phaseFree: begin
                if (flushReq) begin
                    phaseNext = cacheFlushPkg::phaseSendRequest;
                end
            end
            cacheFlushPkg::phaseSendRequest: begin
                // Both caches must be idle before either is started
                if (icFlushReqAck && dcFlushReqAck) begin
                    icFlushReq = 1'b1;
                    dcFlushReq = 1'b1;
                    icDoneNext = 1'b0;
                    dcDoneNext = 1'b0;
                    phaseNext  = cacheFlushPkg::phaseProcessing;
                end
            end
            cacheFlushPkg::phaseProcessing: begin
                if (icFlushComplete) begin
                    icDoneNext = 1'b1;
                end
                if (dcFlushComplete) begin
                    dcDoneNext = 1'b1;
                end
                if (icDoneNext && dcDoneNext) begin
                    phaseNext = cacheFlushPkg::phaseWaiting;
                end
            end
            cacheFlushPkg::phaseWaiting: begin
                // Held until the requester raises flushReq again
                flushComplete = 1'b1;
                if (flushReq) begin
                    phaseNext = cacheFlushPkg::phaseFree;
                end
            end
            default: begin
                phaseNext = cacheFlushPkg::phaseFree;
            end
        endcase
    end

endmodule

// ==== icacheInvalidator.sv ====
/*
 * Instruction cache invalidator
 * Valid and tag per line with fill and lookup ports; a flush clears
 * the valid bits one line per cycle
 */
`timescale 1ns/10ps
`include "cacheFlush_settings.svh"

module icacheInvalidator (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    fillValid,
    input  cacheFlushPkg::lineIndexT fillIndex,
    input  cacheFlushPkg::tagT      fillTag,
    output logic                    fillReady,
    input  cacheFlushPkg::lineIndexT lookupIndex,
    input  cacheFlushPkg::tagT      lookupTag,
    output logic                    lookupHit,
    input  logic                    icFlushReq,
    output logic                    icFlushReqAck,
    output logic                    icFlushComplete
);

    localparam cacheFlushPkg::lineIndexT LastIndex = cacheFlushPkg::lineIndexT'(`CF_LINES - 1);

    logic [`CF_LINES-1:0] validBits;
    cacheFlushPkg::tagT tagArr [`CF_LINES];

    logic flushing;
    cacheFlushPkg::lineIndexT clearIdx;

    assign fillReady     = !flushing;
    assign icFlushReqAck = !flushing;
    assign lookupHit     = validBits[lookupIndex] && (tagArr[lookupIndex] == lookupTag);

    always_ff @(posedge clk) begin
        if (fillValid && fillReady) begin
            tagArr[fillIndex] <= fillTag;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            validBits       <= '0;
            flushing        <= 1'b0;
            clearIdx        <= '0;
            icFlushComplete <= 1'b0;
        end else begin
            icFlushComplete <= 1'b0;
            if (fillValid && fillReady) begin
                validBits[fillIndex] <= 1'b1;
            end
            if (icFlushReq && !flushing) begin
                flushing <= 1'b1;
                clearIdx <= '0;
            end else if (flushing) begin
                validBits[clearIdx] <= 1'b0;
                clearIdx            <= clearIdx + 1'b1;
                if (clearIdx == LastIndex) begin
                    // Completion lands in the cycle after the last clear
                    flushing        <= 1'b0;
                    icFlushComplete <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== dcacheFlushWalker.sv ====
/*
 * Data cache flush walker
 * Tag, data and dirty state per line with a store port; on a flush it
 * scans the lines in order and offers each dirty one as a writeback
 */
`timescale 1ns/10ps
`include "cacheFlush_settings.svh"

module dcacheFlushWalker (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     storeValid,
    input  cacheFlushPkg::lineIndexT storeIndex,
    input  cacheFlushPkg::tagT       storeTag,
    input  cacheFlushPkg::lineDataT  storeData,
    output logic                     storeReady,
    input  logic                     dcFlushReq,
    output logic                     dcFlushReqAck,
    output logic                     wbValid,
    input  logic                     wbReady,
    output cacheFlushPkg::memAddrT   wbAddr,
    output cacheFlushPkg::lineDataT  wbData,
    output logic                     walkDone,
    input  logic                     drainBusy
);

    localparam cacheFlushPkg::lineIndexT LastIndex = cacheFlushPkg::lineIndexT'(`CF_LINES - 1);

    logic [`CF_LINES-1:0] dirtyBits;
    cacheFlushPkg::tagT      tagArr  [`CF_LINES];
    cacheFlushPkg::lineDataT dataArr [`CF_LINES];

    cacheFlushPkg::walkStateT state;
    cacheFlushPkg::lineIndexT scanIdx;

    logic storeFire;
    logic curDirty;
    logic advance;

    // Stores are held off for the whole flush, drain included
    assign storeReady    = (state == cacheFlushPkg::walkIdle) && !drainBusy;
    assign dcFlushReqAck = (state == cacheFlushPkg::walkIdle) && !drainBusy;
    assign storeFire     = storeValid && storeReady;

    assign curDirty = dirtyBits[scanIdx];
    assign wbValid  = (state == cacheFlushPkg::walkScan) && curDirty;
    assign wbAddr   = {tagArr[scanIdx], scanIdx};
    assign wbData   = dataArr[scanIdx];
    assign walkDone = (state == cacheFlushPkg::walkDone);

    // Clean lines pass in one cycle, dirty ones wait for the FIFO
    assign advance = (state == cacheFlushPkg::walkScan) && (!curDirty || wbReady);

    always_ff @(posedge clk) begin
        if (storeFire) begin
            tagArr[storeIndex]  <= storeTag;
            dataArr[storeIndex] <= storeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dirtyBits <= '0;
        end else begin
            if (storeFire) begin
                dirtyBits[storeIndex] <= 1'b1;
            end
            if (wbValid && wbReady) begin
                dirtyBits[scanIdx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= cacheFlushPkg::walkIdle;
            scanIdx <= '0;
        end else begin
            case (state)
                cacheFlushPkg::walkIdle: begin
                    if (dcFlushReq) begin
                        state   <= cacheFlushPkg::walkScan;
                        scanIdx <= '0;
                    end
                end
                cacheFlushPkg::walkScan: begin
                    if (advance) begin
                        if (scanIdx == LastIndex) begin
                            state <= cacheFlushPkg::walkDone;
                        end else begin
                            scanIdx <= scanIdx + 1'b1;
                        end
                    end
                end
                cacheFlushPkg::walkDone: begin
                    // One cycle only, the drain latches it
                    state <= cacheFlushPkg::walkIdle;
                end
                default: begin
                    state <= cacheFlushPkg::walkIdle;
                end
            endcase
        end
    end

endmodule

// ==== writebackFifo.sv ====
/*
 * Writeback FIFO
 * Circular buffer of address and data entries with valid/ready on
 * both sides; any depth of two or more
 */
`timescale 1ns/10ps
`include "cacheFlush_settings.svh"

module writebackFifo #(
    parameter int Depth = `CF_FIFO_DEPTH
) (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    output logic                    inReady,
    input  cacheFlushPkg::memAddrT  inAddr,
    input  cacheFlushPkg::lineDataT inData,
    output logic                    outValid,
    input  logic                    outReady,
    output cacheFlushPkg::memAddrT  outAddr,
    output cacheFlushPkg::lineDataT outData,
    output logic                    empty
);

    localparam int PtrBits = $clog2(Depth);
    localparam int CountBits = $clog2(Depth + 1);
    localparam logic [PtrBits-1:0] LastPtr = PtrBits'(Depth - 1);

    cacheFlushPkg::memAddrT  addrMem [Depth];
    cacheFlushPkg::lineDataT dataMem [Depth];

    logic [PtrBits-1:0] wrPtr, rdPtr;
    logic [CountBits-1:0] count;
    logic push, pop;

    assign inReady  = (count != CountBits'(Depth));
    assign outValid = (count != '0);
    assign empty    = (count == '0);
    assign outAddr  = addrMem[rdPtr];
    assign outData  = dataMem[rdPtr];

    assign push = inValid && inReady;
    assign pop  = outValid && outReady;

    always_ff @(posedge clk) begin
        if (push) begin
            addrMem[wrPtr] <= inAddr;
            dataMem[wrPtr] <= inData;
        end
    end

    // Explicit wrap so non power of two depths work
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LastPtr) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LastPtr) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== writebackDrain.sv ====
/*
 * Writeback drain
 * Moves FIFO entries into a memory output register and reports data
 * cache flush completion once the walk is over and all writes are out
 */
`timescale 1ns/10ps

module writebackDrain (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    output logic                    inReady,
    input  cacheFlushPkg::memAddrT  inAddr,
    input  cacheFlushPkg::lineDataT inData,
    input  logic                    fifoEmpty,
    input  logic                    walkDone,
    output logic                    drainBusy,
    output logic                    memValid,
    input  logic                    memReady,
    output cacheFlushPkg::memAddrT  memAddr,
    output cacheFlushPkg::lineDataT memData,
    output logic                    dcFlushComplete
);

    logic pending;

    // Register is free when empty or being emptied this cycle
    assign inReady         = !memValid || memReady;
    assign drainBusy       = pending;
    assign dcFlushComplete = pending && fifoEmpty && !memValid;

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            memAddr <= inAddr;
            memData <= inData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memValid <= 1'b0;
            pending  <= 1'b0;
        end else begin
            if (inValid && inReady) begin
                memValid <= 1'b1;
            end else if (memReady) begin
                memValid <= 1'b0;
            end
            if (walkDone) begin
                pending <= 1'b1;
            end else if (dcFlushComplete) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

// ==== cacheFlushTop.sv ====
/*
 * Cache flush subsystem top
 * Flush manager with the instruction cache invalidator and the data
 * cache walker, writeback FIFO and drain
 */
`timescale 1ns/10ps
`include "cacheFlush_settings.svh"

module cacheFlushTop (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     flushReq,
    output logic                     flushComplete,
    input  logic                     fillValid,
    input  cacheFlushPkg::lineIndexT fillIndex,
    input  cacheFlushPkg::tagT       fillTag,
    output logic                     fillReady,
    input  cacheFlushPkg::lineIndexT lookupIndex,
    input  cacheFlushPkg::tagT       lookupTag,
    output logic                     lookupHit,
    input  logic                     storeValid,
    input  cacheFlushPkg::lineIndexT storeIndex,
    input  cacheFlushPkg::tagT       storeTag,
    input  cacheFlushPkg::lineDataT  storeData,
    output logic                     storeReady,
    output logic                     memValid,
    output cacheFlushPkg::memAddrT   memAddr,
    output cacheFlushPkg::lineDataT  memData,
    input  logic                     memReady
);

    logic icFlushReqAck, dcFlushReqAck;
    logic icFlushReq, dcFlushReq;
    logic icFlushComplete, dcFlushComplete;

    // Walker to FIFO
    logic wbValid, wbReady;
    cacheFlushPkg::memAddrT  wbAddr;
    cacheFlushPkg::lineDataT wbData;

    // FIFO to drain
    logic fifoValid, fifoReady, fifoEmpty;
    cacheFlushPkg::memAddrT  fifoAddr;
    cacheFlushPkg::lineDataT fifoData;

    logic walkDone, drainBusy;

    cacheFlushManager u_manager (
        .clk(clk), .rstN(rstN),
        .flushReq(flushReq), .flushComplete(flushComplete),
        .icFlushReqAck(icFlushReqAck), .dcFlushReqAck(dcFlushReqAck),
        .icFlushReq(icFlushReq), .dcFlushReq(dcFlushReq),
        .icFlushComplete(icFlushComplete), .dcFlushComplete(dcFlushComplete)
    );

    icacheInvalidator u_icache (
        .clk(clk), .rstN(rstN),
        .fillValid(fillValid), .fillIndex(fillIndex), .fillTag(fillTag),
        .fillReady(fillReady),
        .lookupIndex(lookupIndex), .lookupTag(lookupTag), .lookupHit(lookupHit),
        .icFlushReq(icFlushReq), .icFlushReqAck(icFlushReqAck),
        .icFlushComplete(icFlushComplete)
    );

    dcacheFlushWalker u_walker (
        .clk(clk), .rstN(rstN),
        .storeValid(storeValid), .storeIndex(storeIndex), .storeTag(storeTag),
        .storeData(storeData), .storeReady(storeReady),
        .dcFlushReq(dcFlushReq), .dcFlushReqAck(dcFlushReqAck),
        .wbValid(wbValid), .wbReady(wbReady), .wbAddr(wbAddr), .wbData(wbData),
        .walkDone(walkDone), .drainBusy(drainBusy)
    );

    writebackFifo #(.Depth(`CF_FIFO_DEPTH)) u_fifo (
        .clk(clk), .rstN(rstN),
        .inValid(wbValid), .inReady(wbReady), .inAddr(wbAddr), .inData(wbData),
        .outValid(fifoValid), .outReady(fifoReady),
        .outAddr(fifoAddr), .outData(fifoData),
        .empty(fifoEmpty)
    );

    writebackDrain u_drain (
        .clk(clk), .rstN(rstN),
        .inValid(fifoValid), .inReady(fifoReady), .inAddr(fifoAddr), .inData(fifoData),
        .fifoEmpty(fifoEmpty), .walkDone(walkDone), .drainBusy(drainBusy),
        .memValid(memValid), .memReady(memReady), .memAddr(memAddr), .memData(memData),
        .dcFlushComplete(dcFlushComplete)
    );

endmodule

// ==== cacheFlush_assert.sv ====
/*
 * Cache flush protocol assertions
 * Memory write stability, completion only after a request, and stores
 * held off while the data cache walker is busy
 */
`timescale 1ns/10ps

module cacheFlushAssert (
    input logic                      clk,
    input logic                      rstN,
    input logic                      flushReq,
    input logic                      flushComplete,
    input logic                      storeReady,
    input logic                      memValid,
    input logic                      memReady,
    input cacheFlushPkg::memAddrT    memAddr,
    input cacheFlushPkg::lineDataT   memData,
    input cacheFlushPkg::walkStateT  walkState
);

    int assertFails = 0;

    // Request seen since the last completion
    logic reqSeen;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            reqSeen <= 1'b0;
        end else if (flushComplete) begin
            reqSeen <= 1'b0;
        end else if (flushReq) begin
            reqSeen <= 1'b1;
        end
    end

    memHeld: assert property (@(posedge clk) disable iff (!rstN)
        memValid && !memReady |=> memValid && $stable(memAddr) && $stable(memData))
    else begin
        assertFails++;
        $error("memory write dropped or changed before memReady");
    end

    completeAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        $rose(flushComplete) |-> reqSeen)
    else begin
        assertFails++;
        $error("flushComplete rose without a flush request");
    end

    storeBlocked: assert property (@(posedge clk) disable iff (!rstN)
        walkState != cacheFlushPkg::walkIdle |-> !storeReady)
    else begin
        assertFails++;
        $error("storeReady high while the walker is busy");
    end

endmodule

bind cacheFlushTop cacheFlushAssert u_assert (
    .clk(clk),
    .rstN(rstN),
    .flushReq(flushReq),
    .flushComplete(flushComplete),
    .storeReady(storeReady),
    .memValid(memValid),
    .memReady(memReady),
    .memAddr(memAddr),
    .memData(memData),
    .walkState(u_walker.state)
);

// ==== tbCacheFlush.sv ====
/*
 * Cache flush subsystem testbench
 * Random fills and stores, then flushes under random memory back-pressure,
 * all checked against a reference model of both caches
 */
`timescale 1ns/10ps
`include "cacheFlush_settings.svh"

module tbCacheFlush;

    localparam int WaitLimit = 2000;

    logic clk;
    logic rstN;
    logic flushReq;
    logic flushComplete;
    logic fillValid;
    cacheFlushPkg::lineIndexT fillIndex;
    cacheFlushPkg::tagT fillTag;
    logic fillReady;
    cacheFlushPkg::lineIndexT lookupIndex;
    cacheFlushPkg::tagT lookupTag;
    logic lookupHit;
    logic storeValid;
    cacheFlushPkg::lineIndexT storeIndex;
    cacheFlushPkg::tagT storeTag;
    cacheFlushPkg::lineDataT storeData;
    logic storeReady;
    logic memValid;
    cacheFlushPkg::memAddrT memAddr;
    cacheFlushPkg::lineDataT memData;
    logic memReady;

    // Reference model of both caches
    cacheFlushPkg::tagT      dcTag [`CF_LINES];
    cacheFlushPkg::lineDataT dcData [`CF_LINES];
    logic                    dcDirty [`CF_LINES];
    cacheFlushPkg::tagT      icTag [`CF_LINES];
    logic                    icValid [`CF_LINES];

    // Writebacks still owed to memory in ascending index order
    cacheFlushPkg::memAddrT  expAddrQ [$];
    cacheFlushPkg::lineDataT expDataQ [$];

    logic [31:0] mainSeed;
    logic [31:0] readySeed;

    cacheFlushTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [15:0] randHalf();
        mainSeed = lcgNext(mainSeed);
        return mainSeed[31:16];
    endfunction

    task automatic failRun(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkAddr(input string name, input cacheFlushPkg::memAddrT got,
                             input cacheFlushPkg::memAddrT exp);
        if (got !== exp) begin
            failRun($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic checkData(input string name, input cacheFlushPkg::lineDataT got,
                             input cacheFlushPkg::lineDataT exp);
        if (got !== exp) begin
            failRun($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic fillLine(input cacheFlushPkg::lineIndexT idx, input cacheFlushPkg::tagT tag);
        int waitCount;
        waitCount = 0;
        fillValid = 1'b1;
        fillIndex = idx;
        fillTag   = tag;
        while (!fillReady) begin
            @(negedge clk);
            waitCount++;
            if (waitCount > WaitLimit) begin
                failRun("timeout waiting for the instruction cache to accept a fill");
            end
        end
        // Taken on the coming rising edge
        icValid[idx] = 1'b1;
        icTag[idx]   = tag;
        @(negedge clk);
        fillValid = 1'b0;
    endtask

    task automatic storeLine(input cacheFlushPkg::lineIndexT idx, input cacheFlushPkg::tagT tag,
                             input cacheFlushPkg::lineDataT data);
        int waitCount;
        waitCount = 0;
        storeValid = 1'b1;
        storeIndex = idx;
        storeTag   = tag;
        storeData  = data;
        while (!storeReady) begin
            @(negedge clk);
            waitCount++;
            if (waitCount > WaitLimit) begin
                failRun("timeout waiting for the data cache to accept a store");
            end
        end
        dcTag[idx]   = tag;
        dcData[idx]  = data;
        dcDirty[idx] = 1'b1;
        @(negedge clk);
        storeValid = 1'b0;
    endtask

    // First pass looks up the model tag and the second a tag that never matches
    task automatic checkLookups(input logic holdComplete);
        cacheFlushPkg::lineIndexT idx;
        cacheFlushPkg::tagT tag;
        for (int i = 0; i < 2 * `CF_LINES; i++) begin
            @(negedge clk);
            if (holdComplete) begin
                checkBit("flushComplete", flushComplete, 1'b1);
            end
            idx = i[`CF_INDEX_BITS-1:0];
            tag = (i < `CF_LINES) ? icTag[idx] : (icTag[idx] ^ 8'h5a);
            lookupIndex = idx;
            lookupTag   = tag;
            #10;
            checkBit("lookupHit", lookupHit, (i < `CF_LINES) ? icValid[idx] : 1'b0);
        end
    endtask

    task automatic runFlush();
        int waitCount;
        waitCount = 0;
        for (int i = 0; i < `CF_LINES; i++) begin
            if (dcDirty[i]) begin
                expAddrQ.push_back({dcTag[i], i[`CF_INDEX_BITS-1:0]});
                expDataQ.push_back(dcData[i]);
            end
        end
        flushReq = 1'b1;
        @(negedge clk);
        flushReq = 1'b0;
        while (!flushComplete) begin
            @(negedge clk);
            waitCount++;
            if (waitCount > WaitLimit) begin
                failRun("timeout waiting for flushComplete");
            end
        end
        if (expAddrQ.size() != 0) begin
            failRun($sformatf("flush completed with %0d writebacks never written",
                              expAddrQ.size()));
        end
        for (int i = 0; i < `CF_LINES; i++) begin
            dcDirty[i] = 1'b0;
            icValid[i] = 1'b0;
        end
        // Every line must now miss while the completion is held
        checkLookups(1'b1);
        @(negedge clk);
        checkBit("flushComplete", flushComplete, 1'b1);
        flushReq = 1'b1;
        @(negedge clk);
        flushReq = 1'b0;
        checkBit("flushComplete", flushComplete, 1'b0);
    endtask

    // Random memory ready and an in-order check of every accepted write
    initial begin
        readySeed = 32'd69876;
        forever begin
            @(negedge clk);
            readySeed = lcgNext(readySeed);
            memReady  = (readySeed[31:29] < 3'd3);
            if (memValid && memReady) begin
                if (expAddrQ.size() == 0) begin
                    failRun("memory write seen with no writeback expected");
                end else begin
                    checkAddr("memAddr", memAddr, expAddrQ.pop_front());
                    checkData("memData", memData, expDataQ.pop_front());
                end
            end
        end
    end

    initial begin
        cacheFlushPkg::lineIndexT idx;
        cacheFlushPkg::tagT tag;
        cacheFlushPkg::lineDataT data;
        rstN        = 1'b0;
        flushReq    = 1'b0;
        fillValid   = 1'b0;
        fillIndex   = '0;
        fillTag     = '0;
        lookupIndex = '0;
        lookupTag   = '0;
        storeValid  = 1'b0;
        storeIndex  = '0;
        storeTag    = '0;
        storeData   = '0;
        memReady    = 1'b0;
        mainSeed    = 32'd69876;
        for (int i = 0; i < `CF_LINES; i++) begin
            dcTag[i]   = '0;
            dcData[i]  = '0;
            dcDirty[i] = 1'b0;
            icTag[i]   = '0;
            icValid[i] = 1'b0;
        end

        repeat (4) @(negedge clk);
        rstN = 1'b1;
        checkBit("storeReady", storeReady, 1'b1);
        checkBit("fillReady", fillReady, 1'b1);
        checkBit("memValid", memValid, 1'b0);
        checkBit("flushComplete", flushComplete, 1'b0);

        // Last round flushes again with nothing new to write
        for (int round = 0; round < 3; round++) begin
            if (round < 2) begin
                repeat (10) begin
                    idx = cacheFlushPkg::lineIndexT'(randHalf());
                    tag = cacheFlushPkg::tagT'(randHalf());
                    fillLine(idx, tag);
                end
                repeat (12) begin
                    idx  = cacheFlushPkg::lineIndexT'(randHalf());
                    tag  = cacheFlushPkg::tagT'(randHalf());
                    data = {randHalf(), randHalf()};
                    storeLine(idx, tag, data);
                end
            end
            checkLookups(1'b0);
            runFlush();
        end

        @(negedge clk);
        if (dut.u_assert.assertFails == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            failRun($sformatf("%0d protocol assertions failed", dut.u_assert.assertFails));
        end
    end

endmodule

// ==== compile.f ====
+incdir+.
cacheFlushPkg.sv
cacheFlushManager.sv
icacheInvalidator.sv
dcacheFlushWalker.sv
writebackFifo.sv
writebackDrain.sv
cacheFlushTop.sv
cacheFlush_assert.sv
tbCacheFlush.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tbCacheFlush
FILELIST  ?= compile.f
SIMFLAGS  ?= +verilator+error+limit+1000
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
